// File: hw/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    typedef logic [11:0] vram_addr_t;    // Word address into video memory
    typedef logic [31:0] vram_word_t;
    typedef logic [23:0] color_t;        // 8 bits each of R, G and B
    typedef logic [2:0]  color_index_t;  // {palette bit, 2-bit pixel value}
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

    // Fetcher side of the four-phase handshake
    typedef struct packed {
        logic       req;
        vram_addr_t addr;  // Held stable while req is high
    } vram_req_t;

    // Arbiter side, data is valid while ack is high
    typedef struct packed {
        logic       ack;
        vram_word_t data;
    } vram_rsp_t;

    // Memory map in words.
    // One map word holds four 8-bit entries of {palette, tile id[6:0]}
    localparam vram_addr_t MAP_BASE = 12'd0;
    localparam vram_addr_t GFX_BASE = 12'd512;   // 16 row words per tile
    localparam vram_addr_t PAL_BASE = 12'd2560;  // Color in bits 23:0

    localparam int TILE_PIXELS  = 16;  // Pixels per row and rows per tile
    localparam int PALETTE_SIZE = 8;

endpackage

`default_nettype wire

// File: hw/vram_arbiter.sv
`default_nettype none

module vram_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  ppu_pkg::vram_req_t  pal_req,
    input  ppu_pkg::vram_req_t  line_req,
    output ppu_pkg::vram_rsp_t  pal_rsp,
    output ppu_pkg::vram_rsp_t  line_rsp,
    output logic                mem_rd,
    output ppu_pkg::vram_addr_t mem_addr,
    input  ppu_pkg::vram_word_t mem_data
);
    import ppu_pkg::*;

    typedef enum logic [1:0] {IDLE, READ, RESPOND, RELEASE} state_t;

    state_t     state;
    logic       pick_line;  // Client granted if a read starts now
    logic       last_line;  // Last client served, also owns the current transaction
    logic       owner_req;
    vram_word_t data_q;

    // Alternate when both ask, otherwise whoever asks
    assign pick_line = line_req.req && (!pal_req.req || !last_line);
    assign owner_req = last_line ? line_req.req : pal_req.req;

    // Read goes out in the same cycle the request is seen
    assign mem_rd   = (state == IDLE) && (pal_req.req || line_req.req);
    assign mem_addr = pick_line ? line_req.addr : pal_req.addr;

    assign pal_rsp.ack   = (state == RESPOND) && !last_line;
    assign pal_rsp.data  = data_q;
    assign line_rsp.ack  = (state == RESPOND) && last_line;
    assign line_rsp.data = data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            last_line <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (mem_rd) begin
                        last_line <= pick_line;
                        state     <= READ;
                    end
                end
                READ:    state <= RESPOND;                  // Word arrives this cycle
                RESPOND: if (!owner_req) state <= RELEASE;  // Owner took the data
                RELEASE: state <= IDLE;                     // ack is seen low here
                default: state <= IDLE;
            endcase
        end
    end

    // Response word is held until the next read
    always_ff @(posedge clk) begin
        if (state == READ) begin
            data_q <= mem_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/palette_loader.sv
`default_nettype none

module palette_loader (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  vblank,
    output ppu_pkg::vram_req_t    vram_req,
    input  ppu_pkg::vram_rsp_t    vram_rsp,
    input  ppu_pkg::color_index_t color_index,
    output ppu_pkg::color_t       color
);
    import ppu_pkg::*;

    color_t       palette [PALETTE_SIZE];
    color_index_t entry;     // Palette word being fetched
    logic         busy;
    logic         req_q;
    logic         vblank_q;

    assign vram_req.req  = req_q;
    assign vram_req.addr = PAL_BASE + vram_addr_t'(entry);

    assign color = palette[color_index];  // Lookup for the pixel path

    always_ff @(posedge clk) begin
        if (reset) begin
            vblank_q <= 1'b0;
            busy     <= 1'b0;
            req_q    <= 1'b0;
            entry    <= '0;
            for (int i = 0; i < PALETTE_SIZE; i++) begin
                palette[i] <= '0;
            end
        end else begin
            vblank_q <= vblank;
            if (vblank && !vblank_q && !busy) begin
                busy  <= 1'b1;
                entry <= '0;
            end
            if (busy) begin
                if (!req_q && !vram_rsp.ack) begin
                    req_q <= 1'b1;  // Previous ack has gone low
                end else if (req_q && vram_rsp.ack) begin
                    // Each color takes effect as soon as it is captured
                    palette[entry] <= vram_rsp.data[23:0];
                    req_q          <= 1'b0;
                    entry          <= entry + 3'd1;
                    if (entry == color_index_t'(PALETTE_SIZE - 1)) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/line_fetcher.sv
`default_nettype none

module line_fetcher #(
    parameter int LINE_TILES = 40
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          hsync,
    input  ppu_pkg::vcount_t              vcount,
    output ppu_pkg::vram_req_t            vram_req,
    input  ppu_pkg::vram_rsp_t            vram_rsp,
    output logic                          line_ready,
    input  logic [$clog2(LINE_TILES)-1:0] tile_index,
    output ppu_pkg::vram_word_t           tile_row,
    output logic                          tile_palette
);
    import ppu_pkg::*;

    localparam int TILE_W    = $clog2(LINE_TILES);
    localparam int MAP_WORDS = LINE_TILES / 4;  // Map words per tile row

    typedef enum logic [1:0] {IDLE, MAP, GFX} state_t;

    state_t            state;
    logic              hsync_q;
    logic              req_q;
    vcount_t           line_q;    // Line latched at hsync
    logic [TILE_W-1:0] tile;      // Tile of the line being fetched
    vram_word_t        map_word;
    logic [7:0]        entry;     // {palette, tile id} of the current tile
    vram_addr_t        map_addr;
    vram_addr_t        gfx_addr;

    // Line buffer
    vram_word_t            line_gfx [LINE_TILES];
    logic [LINE_TILES-1:0] line_pal;

    assign entry = map_word[{tile[1:0], 3'b000} +: 8];

    // Tile row is line / 16, row within the tile is line % 16
    assign map_addr = MAP_BASE + vram_addr_t'(line_q[9:4]) * vram_addr_t'(MAP_WORDS)
                    + vram_addr_t'(tile >> 2);
    assign gfx_addr = GFX_BASE + vram_addr_t'({entry[6:0], line_q[3:0]});

    assign vram_req.req  = req_q;
    assign vram_req.addr = (state == GFX) ? gfx_addr : map_addr;

    assign tile_row     = line_gfx[tile_index];
    assign tile_palette = line_pal[tile_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            hsync_q    <= 1'b0;
            req_q      <= 1'b0;
            line_q     <= '0;
            tile       <= '0;
            line_ready <= 1'b0;
            line_pal   <= '0;
            for (int i = 0; i < LINE_TILES; i++) begin
                line_gfx[i] <= '0;
            end
        end else begin
            hsync_q <= hsync;
            if (hsync && !hsync_q) begin
                line_ready <= 1'b0;
                if (state == IDLE) begin
                    line_q <= vcount;
                    tile   <= '0;
                    state  <= MAP;
                end
            end
            if (state != IDLE) begin
                if (!req_q && !vram_rsp.ack) begin
                    req_q <= 1'b1;
                end else if (req_q && vram_rsp.ack) begin
                    req_q <= 1'b0;
                    if (state == MAP) begin
                        map_word <= vram_rsp.data;  // Entries for the next four tiles
                        state    <= GFX;
                    end else begin
                        line_gfx[tile] <= vram_rsp.data;
                        line_pal[tile] <= entry[7];
                        if (tile == TILE_W'(LINE_TILES - 1)) begin
                            state      <= IDLE;
                            line_ready <= 1'b1;
                        end else begin
                            tile <= tile + 1'b1;
                            if (tile[1:0] == 2'd3) begin
                                state <= MAP;  // Group of four done
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_generator.sv
`default_nettype none

module pixel_generator #(
    parameter int LINE_TILES = 40
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          vblank,
    input  logic                          hsync,
    input  ppu_pkg::hcount_t              hcount,
    output logic [$clog2(LINE_TILES)-1:0] tile_index,
    input  ppu_pkg::vram_word_t           tile_row,
    input  logic                          tile_palette,
    output ppu_pkg::color_index_t         color_index,
    input  ppu_pkg::color_t               color,
    output ppu_pkg::color_t               pixel_color
);
    import ppu_pkg::*;

    localparam int      TILE_W      = $clog2(LINE_TILES);
    localparam hcount_t LINE_PIXELS = hcount_t'(LINE_TILES * TILE_PIXELS);

    logic [3:0] pixel;       // Pixel within the tile row
    logic [1:0] pixel_bits;
    logic       blank;

    // hcount / 16 picks the tile, hcount % 16 the pixel
    assign tile_index  = hcount[4 +: TILE_W];
    assign pixel       = hcount[3:0];
    assign pixel_bits  = tile_row[{pixel, 1'b0} +: 2];  // Pixel p in bits 2p+1:2p
    assign color_index = {tile_palette, pixel_bits};

    assign blank = vblank || hsync || (hcount >= LINE_PIXELS);

    // One cycle from hcount to color
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_color <= '0;
        end else if (blank) begin
            pixel_color <= '0;  // Black outside the active line
        end else begin
            pixel_color <= color;
        end
    end

endmodule

`default_nettype wire

// File: hw/ppu_top.sv
`default_nettype none

module ppu_top #(
    parameter int LINE_TILES = 40
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                vblank,
    input  logic                hsync,
    input  ppu_pkg::hcount_t    hcount,
    input  ppu_pkg::vcount_t    vcount,
    output logic                mem_rd,
    output ppu_pkg::vram_addr_t mem_addr,
    input  ppu_pkg::vram_word_t mem_data,
    output logic                line_ready,
    output ppu_pkg::color_t     pixel_color
);
    import ppu_pkg::*;

    vram_req_t                     pal_req;
    vram_req_t                     line_req;
    vram_rsp_t                     pal_rsp;
    vram_rsp_t                     line_rsp;
    logic [$clog2(LINE_TILES)-1:0] tile_index;
    vram_word_t                    tile_row;
    logic                          tile_palette;
    color_index_t                  color_index;
    color_t                        color;

    vram_arbiter i_vram_arbiter (
        .clk      (clk),
        .reset    (reset),
        .pal_req  (pal_req),
        .line_req (line_req),
        .pal_rsp  (pal_rsp),
        .line_rsp (line_rsp),
        .mem_rd   (mem_rd),
        .mem_addr (mem_addr),
        .mem_data (mem_data)
    );

    palette_loader i_palette_loader (
        .clk         (clk),
        .reset       (reset),
        .vblank      (vblank),
        .vram_req    (pal_req),
        .vram_rsp    (pal_rsp),
        .color_index (color_index),
        .color       (color)
    );

    line_fetcher #(
        .LINE_TILES (LINE_TILES)
    ) i_line_fetcher (
        .clk          (clk),
        .reset        (reset),
        .hsync        (hsync),
        .vcount       (vcount),
        .vram_req     (line_req),
        .vram_rsp     (line_rsp),
        .line_ready   (line_ready),
        .tile_index   (tile_index),
        .tile_row     (tile_row),
        .tile_palette (tile_palette)
    );

    pixel_generator #(
        .LINE_TILES (LINE_TILES)
    ) i_pixel_generator (
        .clk          (clk),
        .reset        (reset),
        .vblank       (vblank),
        .hsync        (hsync),
        .hcount       (hcount),
        .tile_index   (tile_index),
        .tile_row     (tile_row),
        .tile_palette (tile_palette),
        .color_index  (color_index),
        .color        (color),
        .pixel_color  (pixel_color)
    );

endmodule

`default_nettype wire

// File: dv/ppu_chk.sv
`default_nettype none

module ppu_chk (
    input logic               clk,
    input logic               reset,
    input ppu_pkg::vram_req_t pal_req,
    input ppu_pkg::vram_req_t line_req,
    input ppu_pkg::vram_rsp_t pal_rsp,
    input ppu_pkg::vram_rsp_t line_rsp,
    input logic               mem_rd
);
    timeunit 1ns;
    timeprecision 1ps;
    import ppu_pkg::*;

    pal_ack_has_req: assert property (@(posedge clk) disable iff (reset)
        $rose(pal_rsp.ack) |-> pal_req.req)
        else $error("palette ack rose without a request");

    line_ack_has_req: assert property (@(posedge clk) disable iff (reset)
        $rose(line_rsp.ack) |-> line_req.req)
        else $error("line ack rose without a request");

    // One response at a time
    acks_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(pal_rsp.ack && line_rsp.ack))
        else $error("both acks high");

    read_needs_open_req: assert property (@(posedge clk) disable iff (reset)
        mem_rd |-> (pal_req.req && !pal_rsp.ack) || (line_req.req && !line_rsp.ack))
        else $error("memory read without an open request");

endmodule

bind vram_arbiter ppu_chk i_ppu_chk (
    .clk      (clk),
    .reset    (reset),
    .pal_req  (pal_req),
    .line_req (line_req),
    .pal_rsp  (pal_rsp),
    .line_rsp (line_rsp),
    .mem_rd   (mem_rd)
);

`default_nettype wire

// File: dv/ppu_tb.sv
`default_nettype none

module ppu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ppu_pkg::*;

    localparam int LINE_TILES     = 8;
    localparam int LINE_PIXELS    = LINE_TILES * TILE_PIXELS;
    localparam int PAL_WAIT       = PALETTE_SIZE * 12 + 20;  // Palette load plus margin
    localparam int LINE_WAIT      = 10 * 12;
    localparam int SCAN           = LINE_PIXELS + 8;
    localparam int TEST_CYCLES    = 13 + 3 * PAL_WAIT + 5 * LINE_WAIT + 5 * SCAN;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

    logic       clk;
    logic       reset;
    logic       vblank;
    logic       hsync;
    hcount_t    hcount;
    vcount_t    vcount;
    logic       mem_rd;
    vram_addr_t mem_addr;
    vram_word_t mem_data;
    logic       line_ready;
    color_t     pixel_color;

    vram_word_t mem [4096];  // Video memory model
    logic       rd_q;
    vram_addr_t addr_q;
    logic [31:0] lfsr;
    int         errors;
    int         checks;
    int         cycle_count;

    ppu_top #(
        .LINE_TILES (LINE_TILES)
    ) i_ppu_top (
        .clk         (clk),
        .reset       (reset),
        .vblank      (vblank),
        .hsync       (hsync),
        .hcount      (hcount),
        .vcount      (vcount),
        .mem_rd      (mem_rd),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .line_ready  (line_ready),
        .pixel_color (pixel_color)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Read data shows up in the cycle after mem_rd
    always @(posedge clk) begin
        rd_q   <= mem_rd;
        addr_q <= mem_addr;
    end

    always @(negedge clk) begin
        if (rd_q) mem_data <= mem[addr_q];
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic fill_random(input int lo, input int hi);
        vram_word_t w;
        for (int a = lo; a <= hi; a++) begin
            w = '0;
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_step(lfsr);  // One step per bit
                w    = {w[30:0], lfsr[0]};
            end
            mem[vram_addr_t'(a)] = w;
        end
    endtask

    function automatic vram_word_t read_word(input int addr);
        return mem[vram_addr_t'(addr)];
    endfunction

    // Color of pixel h on a line, worked out from the memory contents
    function automatic color_t expected_color(input int line, input int h);
        vram_word_t map_word;
        vram_word_t gfx_word;
        vram_word_t pal_word;
        logic [7:0] entry;
        int         tile;
        int         pix;
        if (h >= LINE_PIXELS) return '0;
        tile     = h / TILE_PIXELS;
        map_word = read_word(int'(MAP_BASE) + (line / 16) * (LINE_TILES / 4) + tile / 4);
        entry    = map_word[(tile % 4) * 8 +: 8];
        gfx_word = read_word(int'(GFX_BASE) + int'(entry[6:0]) * 16 + line % 16);
        pix      = int'(gfx_word[2 * (h % 16) +: 2]);
        pal_word = read_word(int'(PAL_BASE) + int'(entry[7]) * 4 + pix);
        return pal_word[23:0];
    endfunction

    task automatic check_color(input string what, input color_t got, input color_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic pulse_vblank();
        vblank = 1'b1;
        @(negedge clk);
        vblank = 1'b0;
    endtask

    task automatic start_line(input int line);
        vcount = vcount_t'(line);
        hsync  = 1'b1;
        @(negedge clk);
        hsync = 1'b0;
    endtask

    task automatic wait_line_ready();
        int n;
        n = 0;
        while (!line_ready && n < LINE_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!line_ready) $display("line fetch did not finish within %0d cycles", LINE_WAIT);
        check_bit("line_ready after fetch", line_ready, 1'b1);
    endtask

    task automatic scan_line(input int line);
        for (int h = 0; h < LINE_PIXELS; h++) begin
            hcount = hcount_t'(h);
            @(negedge clk);
            check_color($sformatf("line %0d pixel %0d", line, h), pixel_color,
                        expected_color(line, h));
        end
    endtask

    task automatic run_reset_test();
        repeat (10) begin
            @(negedge clk);
            check_color("pixel_color after reset", pixel_color, '0);
            check_bit("line_ready after reset", line_ready, 1'b0);
            check_bit("mem_rd after reset", mem_rd, 1'b0);
        end
    endtask

    // Tile k uses palette bit k%2 and every row holds all four pixel values
    task automatic run_palette_test();
        mem[MAP_BASE]      = 32'h8302_8100;
        mem[MAP_BASE + 1]  = 32'h8706_8504;
        for (int k = 0; k < LINE_TILES; k++) begin
            mem[GFX_BASE + vram_addr_t'(k * 16)] = k[0] ? 32'h1B1B_1B1B : 32'hE4E4_E4E4;
        end
        pulse_vblank();
        repeat (PAL_WAIT) @(negedge clk);
        start_line(0);
        wait_line_ready();
        scan_line(0);
    endtask

    task automatic run_line_test(input int line);
        start_line(line);
        wait_line_ready();
        scan_line(line);
    endtask

    task automatic run_blanking_test();
        hcount = hcount_t'(10);
        hsync  = 1'b1;
        @(negedge clk);
        check_color("pixel_color during hsync", pixel_color, '0);
        hsync = 1'b0;
        wait_line_ready();
        pulse_vblank();
        check_color("pixel_color during vblank", pixel_color, '0);
        repeat (PAL_WAIT) @(negedge clk);
        for (int h = LINE_PIXELS; h < LINE_PIXELS + 8; h++) begin
            hcount = hcount_t'(h);
            @(negedge clk);
            check_color($sformatf("pixel_color at hcount %0d", h), pixel_color, '0);
        end
    endtask

    // Line fetch overlaps the palette load in the arbiter
    task automatic run_contention_test();
        fill_random(MAP_BASE, PAL_BASE + PALETTE_SIZE - 1);
        pulse_vblank();
        repeat (2) @(negedge clk);
        start_line(37);
        wait_line_ready();
        repeat (PAL_WAIT) @(negedge clk);
        check_bit("line_ready held", line_ready, 1'b1);
        scan_line(37);
    endtask

    initial begin
        reset       = 1'b1;
        vblank      = 1'b0;
        hsync       = 1'b0;
        hcount      = '0;
        vcount      = '0;
        mem_data    = '0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        lfsr        = 32'h639;
        fill_random(0, 4095);
        repeat (3) @(negedge clk);
        reset = 1'b0;

        run_reset_test();
        run_palette_test();
        fill_random(MAP_BASE, PAL_BASE - 1);  // Palette words stay as loaded
        run_line_test(5);
        run_line_test(21);                    // Map row 1 and row 5 in the tile
        run_blanking_test();
        run_contention_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/ppu_pkg.sv
hw/vram_arbiter.sv
hw/palette_loader.sv
hw/line_fetcher.sv
hw/pixel_generator.sv
hw/ppu_top.sv
dv/ppu_chk.sv
dv/ppu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module ppu_tb -o ppu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ppu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1
